// File: Bender.yml
package:
  name: soc_bus

export_include_dirs:
  - common

sources:
  - common/soc_bus_req_pkg.sv
  - common/soc_bus_map_pkg.sv
  - source/soc_addr_decoder.sv
  - xbar/soc_req_arbiter.sv
  - xbar/soc_rsp_router.sv
  - source/soc_bus.sv
  - target: test
    files:
      - verification/tb_soc_bus.sv

// File: common/soc_bus_cfg.svh
/* widths, port counts, buffer depth, address map and target numbering
   of the SoC interconnect */
`ifndef SOC_BUS_CFG_SVH
`define SOC_BUS_CFG_SVH

// datapath widths
`define SOC_AW         32
`define SOC_DW         32
`define SOC_IW_INP     4
`define SOC_IW_OUP     (`SOC_IW_INP + 2)  // initiator index above the id

// port counts, fixed for this address map
`define SOC_N_INIT     4
`define SOC_N_TGT      5

// request and response buffers, also the credit ceiling
`define SOC_FIFO_DEPTH 2

// address map
`define SOC_CL_BASE    32'h1000_0000
`define SOC_CL_STRIDE  32'h0040_0000
`define SOC_CL_SIZE    32'h0030_0000
`define SOC_L2_BASE    32'h1C00_0000
`define SOC_L2_SIZE    32'h0010_0000
`define SOC_DBG_BASE   32'h1A11_0000
`define SOC_DBG_SIZE   32'h0000_1000

// target port numbers
`define SOC_TGT_CL0    0
`define SOC_TGT_CL1    1
`define SOC_TGT_L2     2
`define SOC_TGT_EXT    3  // default for unmapped addresses
`define SOC_TGT_DBG    4

`endif

// File: common/soc_bus_map_pkg.sv
/* port index types, address rule struct and arbiter state */
`include "soc_bus_cfg.svh"

package soc_bus_map_pkg;

  typedef logic [2:0] soc_tgt_idx_t;   // one of five targets
  typedef logic [1:0] soc_init_idx_t;  // one of four initiators

  // one address window, end is exclusive
  typedef struct packed {
    soc_tgt_idx_t       idx;
    logic [`SOC_AW-1:0] start_addr;
    logic [`SOC_AW-1:0] end_addr;
  } soc_rule_t;

  // lock keeps the chosen initiator while the target owes credit
  typedef enum logic {
    ARB_IDLE = 1'b0,
    ARB_LOCK = 1'b1
  } soc_arb_state_e;

endpackage

// File: common/soc_bus_req_pkg.sv
/* request opcode and response status types */
package soc_bus_req_pkg;

  // single beat access kind
  typedef enum logic {
    SOC_OP_READ  = 1'b0,
    SOC_OP_WRITE = 1'b1
  } soc_op_e;

  // set by the target, carried back untouched
  typedef enum logic {
    SOC_RSP_OKAY   = 1'b0,
    SOC_RSP_DECERR = 1'b1
  } soc_status_e;

endpackage

// File: files.f
+incdir+common
common/soc_bus_req_pkg.sv
common/soc_bus_map_pkg.sv
source/soc_addr_decoder.sv
xbar/soc_req_arbiter.sv
xbar/soc_rsp_router.sv
source/soc_bus.sv
verification/tb_soc_bus.sv

// File: source/soc_addr_decoder.sv
/* per-initiator request FIFO with address decode and credit return */
`timescale 1ns/1ps
`include "soc_bus_cfg.svh"

module soc_addr_decoder
  import soc_bus_req_pkg::*, soc_bus_map_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  input  soc_op_e                in_op,
  input  logic [`SOC_AW-1:0]     in_addr,
  input  logic [`SOC_DW-1:0]     in_wdata,
  input  logic [`SOC_IW_INP-1:0] in_id,
  output logic                   in_credit,
  output logic                   head_valid,
  output soc_op_e                head_op,
  output logic [`SOC_AW-1:0]     head_addr,
  output logic [`SOC_DW-1:0]     head_wdata,
  output logic [`SOC_IW_INP-1:0] head_id,
  output soc_tgt_idx_t           head_tgt,
  input  logic                   pop
);

  localparam int unsigned DEPTH   = `SOC_FIFO_DEPTH;
  localparam int unsigned PW      = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW      = $clog2(DEPTH + 1);
  localparam int unsigned N_RULES = 4;

  localparam soc_rule_t [N_RULES-1:0] ADDR_MAP = '{
    '{idx: soc_tgt_idx_t'(`SOC_TGT_DBG), start_addr: `SOC_DBG_BASE,
      end_addr: `SOC_DBG_BASE + `SOC_DBG_SIZE},
    '{idx: soc_tgt_idx_t'(`SOC_TGT_L2), start_addr: `SOC_L2_BASE,
      end_addr: `SOC_L2_BASE + `SOC_L2_SIZE},
    '{idx: soc_tgt_idx_t'(`SOC_TGT_CL1), start_addr: `SOC_CL_BASE + `SOC_CL_STRIDE,
      end_addr: `SOC_CL_BASE + `SOC_CL_STRIDE + `SOC_CL_SIZE},
    '{idx: soc_tgt_idx_t'(`SOC_TGT_CL0), start_addr: `SOC_CL_BASE,
      end_addr: `SOC_CL_BASE + `SOC_CL_SIZE}
  };

  soc_op_e                mem_op    [DEPTH];
  logic [`SOC_AW-1:0]     mem_addr  [DEPTH];
  logic [`SOC_DW-1:0]     mem_wdata [DEPTH];
  logic [`SOC_IW_INP-1:0] mem_id    [DEPTH];
  soc_tgt_idx_t           mem_tgt   [DEPTH];
  logic [PW-1:0]          wr_ptr;
  logic [PW-1:0]          rd_ptr;
  logic [CW-1:0]          fill;
  logic [CW-1:0]          owed;     // credits not yet handed back
  soc_tgt_idx_t           in_tgt;

  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // unmapped falls through to external
  always_comb begin
    in_tgt = soc_tgt_idx_t'(`SOC_TGT_EXT);
    for (int r = 0; r < N_RULES; r++) begin
      if (in_addr >= ADDR_MAP[r].start_addr && in_addr < ADDR_MAP[r].end_addr) begin
        in_tgt = ADDR_MAP[r].idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem_op[wr_ptr]    <= in_op;
      mem_addr[wr_ptr]  <= in_addr;
      mem_wdata[wr_ptr] <= in_wdata;
      mem_id[wr_ptr]    <= in_id;
      mem_tgt[wr_ptr]   <= in_tgt;  // decode stored with the beat
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      owed      <= CW'(DEPTH);  // reset burst, one per slot
      in_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      fill      <= fill + CW'(in_valid) - CW'(pop);
      owed      <= owed + CW'(pop) - CW'(owed != '0);
      in_credit <= owed != '0;
    end
  end

  assign head_valid = fill != '0;
  assign head_op    = mem_op[rd_ptr];
  assign head_addr  = mem_addr[rd_ptr];
  assign head_wdata = mem_wdata[rd_ptr];
  assign head_id    = mem_id[rd_ptr];
  assign head_tgt   = mem_tgt[rd_ptr];

  // initiator must respect its credits
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    in_valid |-> fill != CW'(DEPTH));

  // only a granted head may leave
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    pop |-> fill != '0);

endmodule

// File: source/soc_bus.sv
/* SoC interconnect top: request decoders, per-target arbiters
   and per-initiator response routers */
`timescale 1ns/1ps
`include "soc_bus_cfg.svh"

module soc_bus
  import soc_bus_req_pkg::*, soc_bus_map_pkg::*;
(
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic [`SOC_N_INIT-1:0]                   init_req_valid,
  input  soc_op_e [`SOC_N_INIT-1:0]                init_req_op,
  input  logic [`SOC_N_INIT-1:0][`SOC_AW-1:0]      init_req_addr,
  input  logic [`SOC_N_INIT-1:0][`SOC_DW-1:0]      init_req_wdata,
  input  logic [`SOC_N_INIT-1:0][`SOC_IW_INP-1:0]  init_req_id,
  output logic [`SOC_N_INIT-1:0]                   init_req_credit,
  output logic [`SOC_N_INIT-1:0]                   init_rsp_valid,
  output logic [`SOC_N_INIT-1:0][`SOC_DW-1:0]      init_rsp_rdata,
  output soc_status_e [`SOC_N_INIT-1:0]            init_rsp_status,
  output logic [`SOC_N_INIT-1:0][`SOC_IW_INP-1:0]  init_rsp_id,
  input  logic [`SOC_N_INIT-1:0]                   init_rsp_credit,
  output logic [`SOC_N_TGT-1:0]                    tgt_req_valid,
  output soc_op_e [`SOC_N_TGT-1:0]                 tgt_req_op,
  output logic [`SOC_N_TGT-1:0][`SOC_AW-1:0]       tgt_req_addr,
  output logic [`SOC_N_TGT-1:0][`SOC_DW-1:0]       tgt_req_wdata,
  output logic [`SOC_N_TGT-1:0][`SOC_IW_OUP-1:0]   tgt_req_id,
  input  logic [`SOC_N_TGT-1:0]                    tgt_req_credit,
  input  logic [`SOC_N_TGT-1:0]                    tgt_rsp_valid,
  input  logic [`SOC_N_TGT-1:0][`SOC_DW-1:0]       tgt_rsp_rdata,
  input  soc_status_e [`SOC_N_TGT-1:0]             tgt_rsp_status,
  input  logic [`SOC_N_TGT-1:0][`SOC_IW_OUP-1:0]   tgt_rsp_id,
  output logic [`SOC_N_TGT-1:0]                    tgt_rsp_credit
);

  // FIFO heads, seen by every arbiter
  logic [`SOC_N_INIT-1:0]                  head_valid;
  soc_op_e [`SOC_N_INIT-1:0]               head_op;
  logic [`SOC_N_INIT-1:0][`SOC_AW-1:0]     head_addr;
  logic [`SOC_N_INIT-1:0][`SOC_DW-1:0]     head_wdata;
  logic [`SOC_N_INIT-1:0][`SOC_IW_INP-1:0] head_id;
  soc_tgt_idx_t [`SOC_N_INIT-1:0]          head_tgt;
  logic [`SOC_N_INIT-1:0]                  pop;
  logic [`SOC_N_TGT-1:0][`SOC_N_INIT-1:0]  grant;       // per target, per initiator
  logic [`SOC_N_INIT-1:0][`SOC_N_TGT-1:0]  rsp_credit;  // per router, per target

  for (genvar i = 0; i < `SOC_N_INIT; i++) begin : gen_init
    soc_addr_decoder i_decoder (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (init_req_valid[i]),
      .in_op      (init_req_op[i]),
      .in_addr    (init_req_addr[i]),
      .in_wdata   (init_req_wdata[i]),
      .in_id      (init_req_id[i]),
      .in_credit  (init_req_credit[i]),
      .head_valid (head_valid[i]),
      .head_op    (head_op[i]),
      .head_addr  (head_addr[i]),
      .head_wdata (head_wdata[i]),
      .head_id    (head_id[i]),
      .head_tgt   (head_tgt[i]),
      .pop        (pop[i])
    );

    soc_rsp_router #(
      .INIT_IDX (soc_init_idx_t'(i))
    ) i_router (
      .clk        (clk),
      .rst        (rst),
      .rsp_valid  (tgt_rsp_valid),
      .rsp_rdata  (tgt_rsp_rdata),
      .rsp_status (tgt_rsp_status),
      .rsp_id     (tgt_rsp_id),
      .rsp_credit (rsp_credit[i]),
      .out_valid  (init_rsp_valid[i]),
      .out_rdata  (init_rsp_rdata[i]),
      .out_status (init_rsp_status[i]),
      .out_id     (init_rsp_id[i]),
      .out_credit (init_rsp_credit[i])
    );
  end

  for (genvar t = 0; t < `SOC_N_TGT; t++) begin : gen_tgt
    soc_req_arbiter #(
      .TGT_IDX (soc_tgt_idx_t'(t))
    ) i_arbiter (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (head_valid),
      .req_op     (head_op),
      .req_addr   (head_addr),
      .req_wdata  (head_wdata),
      .req_id     (head_id),
      .req_tgt    (head_tgt),
      .grant      (grant[t]),
      .out_valid  (tgt_req_valid[t]),
      .out_op     (tgt_req_op[t]),
      .out_addr   (tgt_req_addr[t]),
      .out_wdata  (tgt_req_wdata[t]),
      .out_id     (tgt_req_id[t]),
      .out_credit (tgt_req_credit[t])
    );
  end

  // a head goes to one target, so at most one grant per decoder
  always_comb begin
    pop            = '0;
    tgt_rsp_credit = '0;
    for (int t = 0; t < `SOC_N_TGT; t++) begin
      for (int i = 0; i < `SOC_N_INIT; i++) begin
        pop[i]            = pop[i] | grant[t][i];
        tgt_rsp_credit[t] = tgt_rsp_credit[t] | rsp_credit[i][t];
      end
    end
  end

endmodule

// File: verification/tb_soc_bus.sv
/* testbench for the SoC interconnect: initiator and target models,
   scoreboards, credit, latency and fairness checks */
`timescale 1ns/1ps
`include "soc_bus_cfg.svh"

module tb_soc_bus
  import soc_bus_req_pkg::*, soc_bus_map_pkg::*;
();

  localparam int NI    = `SOC_N_INIT;
  localparam int NT    = `SOC_N_TGT;
  localparam int DEPTH = `SOC_FIFO_DEPTH;
  localparam int TMO   = 4000;

  typedef struct packed {
    logic [`SOC_IW_OUP-1:0] id;
    soc_op_e                op;
    logic [`SOC_AW-1:0]     addr;
    logic [`SOC_DW-1:0]     wdata;
  } req_t;

  typedef struct packed {
    logic [`SOC_IW_INP-1:0] id;
    logic [`SOC_DW-1:0]     rdata;
    soc_status_e            status;
  } rsp_t;

  logic                                    clk;
  logic                                    rst;
  logic [NI-1:0]                           init_req_valid;
  soc_op_e [NI-1:0]                        init_req_op;
  logic [NI-1:0][`SOC_AW-1:0]              init_req_addr;
  logic [NI-1:0][`SOC_DW-1:0]              init_req_wdata;
  logic [NI-1:0][`SOC_IW_INP-1:0]          init_req_id;
  logic [NI-1:0]                           init_req_credit;
  logic [NI-1:0]                           init_rsp_valid;
  logic [NI-1:0][`SOC_DW-1:0]              init_rsp_rdata;
  soc_status_e [NI-1:0]                    init_rsp_status;
  logic [NI-1:0][`SOC_IW_INP-1:0]          init_rsp_id;
  logic [NI-1:0]                           init_rsp_credit;
  logic [NT-1:0]                           tgt_req_valid;
  soc_op_e [NT-1:0]                        tgt_req_op;
  logic [NT-1:0][`SOC_AW-1:0]              tgt_req_addr;
  logic [NT-1:0][`SOC_DW-1:0]              tgt_req_wdata;
  logic [NT-1:0][`SOC_IW_OUP-1:0]          tgt_req_id;
  logic [NT-1:0]                           tgt_req_credit;
  logic [NT-1:0]                           tgt_rsp_valid;
  logic [NT-1:0][`SOC_DW-1:0]              tgt_rsp_rdata;
  soc_status_e [NT-1:0]                    tgt_rsp_status;
  logic [NT-1:0][`SOC_IW_OUP-1:0]          tgt_rsp_id;
  logic [NT-1:0]                           tgt_rsp_credit;

  req_t pend [NT][$];  // requests expected at each target
  req_t tq   [NT][$];  // requests held by the target models
  rsp_t rexp [NI][$];  // responses expected per initiator
  int icred[NI], rcred[NI], rowed[NI], req_pulses[NI];
  int tcred[NT], towed[NT], rsp_avail[NT], rsp_pulses[NT];
  int got[NI][NI];     // grants to j while k waits on L2
  int cyc, send_cyc, last_req_cyc, last_trsp_cyc, last_irsp_cyc;
  logic [`SOC_IW_INP-1:0] id_ctr[NI];
  bit eager, any_valid;

  soc_bus i_dut (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  task automatic report_value(string name, logic [63:0] exp, logic [63:0] act);
    $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic report_error(string what);
    $display("ERROR: %s", what);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // address map as specified, misses go to external
  function automatic int expect_target(logic [31:0] a);
    if (a >= `SOC_CL_BASE && a < `SOC_CL_BASE + `SOC_CL_SIZE) return `SOC_TGT_CL0;
    if (a >= `SOC_CL_BASE + `SOC_CL_STRIDE &&
        a < `SOC_CL_BASE + `SOC_CL_STRIDE + `SOC_CL_SIZE) return `SOC_TGT_CL1;
    if (a >= `SOC_L2_BASE && a < `SOC_L2_BASE + `SOC_L2_SIZE) return `SOC_TGT_L2;
    if (a >= `SOC_DBG_BASE && a < `SOC_DBG_BASE + `SOC_DBG_SIZE) return `SOC_TGT_DBG;
    return `SOC_TGT_EXT;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NI; i++) begin
        icred[i] = 0;
        rcred[i] = 0;
        rowed[i] = DEPTH;
        req_pulses[i] = 0;
      end
      for (int t = 0; t < NT; t++) begin
        tcred[t] = 0;
        towed[t] = DEPTH;
        rsp_avail[t] = 0;
        rsp_pulses[t] = 0;
      end
    end else begin
      for (int i = 0; i < NI; i++) begin
        icred[i] += int'(init_req_credit[i]) - int'(init_req_valid[i]);
        rcred[i] += int'(init_rsp_credit[i]) - int'(init_rsp_valid[i]);
        rowed[i] += int'(init_rsp_valid[i]);  // slot freed at once
        req_pulses[i] += int'(init_req_credit[i]);
      end
      for (int t = 0; t < NT; t++) begin
        tcred[t] += int'(tgt_req_credit[t]) - int'(tgt_req_valid[t]);
        rsp_avail[t] += int'(tgt_rsp_credit[t]) - int'(tgt_rsp_valid[t]);
        rsp_pulses[t] += int'(tgt_rsp_credit[t]);
      end
      any_valid |= (|tgt_req_valid) | (|init_rsp_valid);
    end
  end

  // scoreboards for requests at targets and responses at initiators
  always @(posedge clk) begin : monitor
    int k;
    if (!rst) begin
      for (int t = 0; t < NT; t++) begin
        if (tgt_req_valid[t]) begin
          k = -1;
          for (int n = pend[t].size() - 1; n >= 0; n--) begin
            if (pend[t][n].id == tgt_req_id[t]) k = n;
          end
          if (k < 0) report_error($sformatf("unexpected request at target %0d", t));
          assert (pend[t][k].addr == tgt_req_addr[t])
            else report_value("request addr", pend[t][k].addr, tgt_req_addr[t]);
          assert (pend[t][k].op == tgt_req_op[t])
            else report_value("request op", pend[t][k].op, tgt_req_op[t]);
          assert (pend[t][k].wdata == tgt_req_wdata[t])
            else report_value("request wdata", pend[t][k].wdata, tgt_req_wdata[t]);
          tq[t].push_back(pend[t][k]);
          pend[t].delete(k);
          last_req_cyc = cyc;
        end
        if (tgt_rsp_valid[t]) last_trsp_cyc = cyc;
      end
      for (int i = 0; i < NI; i++) begin
        if (init_rsp_valid[i]) begin
          k = -1;
          for (int n = rexp[i].size() - 1; n >= 0; n--) begin
            if (rexp[i][n].id == init_rsp_id[i] && rexp[i][n].rdata == init_rsp_rdata[i]) k = n;
          end
          if (k < 0) report_error($sformatf("unexpected response at initiator %0d", i));
          assert (rexp[i][k].status == init_rsp_status[i])
            else report_value("response status", rexp[i][k].status, init_rsp_status[i]);
          rexp[i].delete(k);
          last_irsp_cyc = cyc;
        end
      end
    end
  end

  // round-robin on the L2 arbiter
  always @(posedge clk) begin : fairness
    bit waiting;
    if (!rst) begin
      for (int k = 0; k < NI; k++) begin
        waiting = i_dut.head_valid[k] && i_dut.head_tgt[k] == `SOC_TGT_L2;
        for (int j = 0; j < NI; j++) begin
          if (waiting && j != k && i_dut.grant[`SOC_TGT_L2][j]) begin
            got[k][j]++;
            assert (got[k][j] < 2) else report_value("fairness grants", 1, got[k][j]);
          end
          if (!waiting || i_dut.grant[`SOC_TGT_L2][k]) got[k][j] = 0;
        end
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) rst |=> (init_req_credit == '0 &&
      tgt_rsp_credit == '0 && tgt_req_valid == '0 && init_rsp_valid == '0))
    else report_error("credit or valid output active during reset");

  for (genvar t = 0; t < NT; t++) begin : gen_tgt
    a_tgt_credit: assert property (@(posedge clk) disable iff (rst)
      tgt_req_valid[t] |-> tcred[t] > 0)
      else report_error($sformatf("request sent to target %0d without credit", t));
    a_rsp_credit_max: assert property (@(posedge clk) disable iff (rst)
      rsp_avail[t] <= DEPTH)
      else report_value("response credit ceiling", DEPTH, $sampled(rsp_avail[t]));

    // target model with random credit and response delay
    initial begin : target
      bit active;
      req_t r;
      forever begin
        @(posedge clk);
        active = !rst;
        #1;
        tgt_req_credit[t] = 1'b0;
        tgt_rsp_valid[t]  = 1'b0;
        if (active && towed[t] > 0 && (eager || $urandom_range(3) != 0)) begin
          tgt_req_credit[t] = 1'b1;
          towed[t]--;
        end
        if (active && tq[t].size() > 0 && rsp_avail[t] > 0 &&
            (eager || $urandom_range(2) == 0)) begin
          r = tq[t].pop_front();
          tgt_rsp_valid[t]  = 1'b1;
          tgt_rsp_rdata[t]  = r.addr;  // echo
          tgt_rsp_id[t]     = r.id;
          tgt_rsp_status[t] = soc_status_e'(r.addr[2]);
          towed[t]++;
        end
      end
    end
  end

  for (genvar i = 0; i < NI; i++) begin : gen_init
    a_rsp_credit: assert property (@(posedge clk) disable iff (rst)
      init_rsp_valid[i] |-> rcred[i] > 0)
      else report_error($sformatf("response sent to initiator %0d without credit", i));
    a_req_credit_max: assert property (@(posedge clk) disable iff (rst)
      icred[i] <= DEPTH)
      else report_value("request credit ceiling", DEPTH, $sampled(icred[i]));

    initial begin : rsp_credit_model
      bit active;
      forever begin
        @(posedge clk);
        active = !rst;
        #1;
        init_rsp_credit[i] = 1'b0;
        if (active && rowed[i] > 0 && (eager || $urandom_range(3) != 0)) begin
          init_rsp_credit[i] = 1'b1;
          rowed[i]--;
        end
      end
    end
  end

  task automatic send_req(int i, logic [31:0] addr, soc_op_e op);
    int n;
    req_t r;
    rsp_t e;
    n = 0;
    while (icred[i] == 0) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TMO) report_error($sformatf("initiator %0d got no request credit", i));
    end
    r.id = {soc_init_idx_t'(i), id_ctr[i]};
    r.op = op;
    r.addr = addr;
    r.wdata = $urandom;
    e.id = id_ctr[i];
    e.rdata = addr;
    e.status = soc_status_e'(addr[2]);
    pend[expect_target(addr)].push_back(r);
    rexp[i].push_back(e);
    id_ctr[i]++;
    init_req_valid[i] = 1'b1;
    init_req_op[i]    = op;
    init_req_addr[i]  = addr;
    init_req_wdata[i] = r.wdata;
    init_req_id[i]    = e.id;
    @(posedge clk);
    send_cyc = cyc;
    #1;
    init_req_valid[i] = 1'b0;
  endtask

  task automatic run_initiator(int i, int kind, int cnt);
    logic [31:0] base [6] = '{`SOC_CL_BASE, `SOC_CL_BASE + `SOC_CL_STRIDE, `SOC_L2_BASE,
                              `SOC_DBG_BASE, 32'h4000_0000, 32'h1030_0000};
    logic [31:0] edges [8] = '{32'h1000_0010, 32'h102F_FFFC, 32'h1030_0000, 32'h1040_0008,
                               32'h1A11_0FFC, 32'h1A11_1000, 32'h1C0F_FFF0, 32'h8000_0000};
    for (int n = 0; n < cnt; n++) begin
      case (kind)
        0: send_req(i, edges[n % 8], soc_op_e'(n[0]));
        1: send_req(i, `SOC_L2_BASE + (n << 2), SOC_OP_WRITE);
        default: send_req(i, base[$urandom_range(5)] + ($urandom_range(255) << 2),
                          soc_op_e'($urandom_range(1)));
      endcase
    end
  endtask

  task automatic run_all(int kind, int cnt);
    for (int i = 0; i < NI; i++) begin
      fork
        automatic int ii = i;
        run_initiator(ii, kind, cnt);
      join_none
    end
    wait fork;
  endtask

  // every credit output has given its reset burst
  task automatic wait_credit_burst();
    int n;
    bit done;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
      done = 1'b1;
      for (int i = 0; i < NI; i++) begin
        if (req_pulses[i] < DEPTH) done = 1'b0;
      end
      for (int t = 0; t < NT; t++) begin
        if (rsp_pulses[t] < DEPTH) done = 1'b0;
      end
      if (n > TMO) report_error("reset credit burst never completed");
    end while (!done);
  endtask

  task automatic wait_idle();
    int n;
    int busy;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
      busy = 0;
      for (int t = 0; t < NT; t++) busy += pend[t].size() + tq[t].size();
      for (int i = 0; i < NI; i++) busy += rexp[i].size();
      if (n > TMO) report_error("outstanding requests or responses never completed");
    end while (busy != 0);
  endtask

  initial begin
    void'($urandom(32'hc8f4d76e));
    rst = 1'b1;
    eager = 1'b1;
    any_valid = 1'b0;
    cyc = 0;
    init_req_valid = '0;
    init_req_op = '{default: SOC_OP_READ};
    init_req_addr = '0;
    init_req_wdata = '0;
    init_req_id = '0;
    init_rsp_credit = '0;
    tgt_req_credit = '0;
    tgt_rsp_valid = '0;
    tgt_rsp_rdata = '0;
    tgt_rsp_status = '{default: SOC_RSP_OKAY};
    tgt_rsp_id = '0;
    for (int i = 0; i < NI; i++) id_ctr[i] = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // reset credit burst on an idle bus
    wait_credit_burst();
    for (int i = 0; i < NI; i++) begin
      assert (req_pulses[i] == DEPTH)
        else report_value("init_req_credit burst", DEPTH, req_pulses[i]);
    end
    for (int t = 0; t < NT; t++) begin
      assert (rsp_pulses[t] == DEPTH)
        else report_value("tgt_rsp_credit burst", DEPTH, rsp_pulses[t]);
    end
    assert (!any_valid) else report_error("valid output during the credit burst");

    send_req(0, `SOC_L2_BASE + 32'h100, SOC_OP_READ);
    wait_idle();
    assert (last_req_cyc - send_cyc == 2)
      else report_value("request latency", 2, last_req_cyc - send_cyc);
    assert (last_irsp_cyc - last_trsp_cyc == 2)
      else report_value("response latency", 2, last_irsp_cyc - last_trsp_cyc);

    eager = 1'b0;
    run_all(0, 8);   // map edges and unmapped holes
    run_all(1, 12);  // all initiators on L2
    run_all(2, 25);
    wait_idle();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: xbar/soc_req_arbiter.sv
/* per-target round-robin request arbiter with credit counter and id widening */
`timescale 1ns/1ps
`include "soc_bus_cfg.svh"

module soc_req_arbiter
  import soc_bus_req_pkg::*, soc_bus_map_pkg::*;
#(
  parameter soc_tgt_idx_t TGT_IDX = '0
) (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic [`SOC_N_INIT-1:0]                   req_valid,
  input  soc_op_e [`SOC_N_INIT-1:0]                req_op,
  input  logic [`SOC_N_INIT-1:0][`SOC_AW-1:0]      req_addr,
  input  logic [`SOC_N_INIT-1:0][`SOC_DW-1:0]      req_wdata,
  input  logic [`SOC_N_INIT-1:0][`SOC_IW_INP-1:0]  req_id,
  input  soc_tgt_idx_t [`SOC_N_INIT-1:0]           req_tgt,
  output logic [`SOC_N_INIT-1:0]                   grant,
  output logic                                     out_valid,
  output soc_op_e                                  out_op,
  output logic [`SOC_AW-1:0]                       out_addr,
  output logic [`SOC_DW-1:0]                       out_wdata,
  output logic [`SOC_IW_OUP-1:0]                   out_id,
  input  logic                                     out_credit
);

  localparam int unsigned N  = `SOC_N_INIT;
  localparam int unsigned CW = $clog2(`SOC_FIFO_DEPTH + 1);

  soc_arb_state_e state_q;
  soc_init_idx_t  prio_q;   // first initiator looked at
  soc_init_idx_t  lock_q;
  soc_init_idx_t  pick;
  soc_init_idx_t  winner;
  logic [N-1:0]   cand;
  logic           found;
  logic           can_send;
  logic           fire;
  logic [CW-1:0]  cnt_q;    // target credits

  always_comb begin
    for (int i = 0; i < N; i++) begin
      cand[i] = req_valid[i] && (req_tgt[i] == TGT_IDX);
    end
  end

  always_comb begin
    int unsigned idx;
    pick  = prio_q;
    found = 1'b0;
    for (int k = 0; k < N; k++) begin
      idx = (int'(prio_q) + k) % N;
      if (!found && cand[idx]) begin
        found = 1'b1;
        pick  = soc_init_idx_t'(idx);
      end
    end
  end

  // beat already on the port still holds one credit
  assign can_send = cnt_q > CW'(out_valid);
  assign winner   = (state_q == ARB_LOCK) ? lock_q : pick;
  assign fire     = can_send && (found || state_q == ARB_LOCK);

  always_comb begin
    grant = '0;
    if (fire) begin
      grant[winner] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= ARB_IDLE;
      prio_q    <= '0;
      lock_q    <= '0;
      cnt_q     <= '0;
      out_valid <= 1'b0;
    end else begin
      cnt_q     <= cnt_q + CW'(out_credit) - CW'(out_valid);
      out_valid <= fire;
      if (fire) begin
        prio_q <= (winner == soc_init_idx_t'(N - 1)) ? '0 : winner + 1'b1;
      end
      case (state_q)
        ARB_IDLE: begin
          if (found && !can_send) begin  // hold choice until credit shows up
            state_q <= ARB_LOCK;
            lock_q  <= pick;
          end
        end
        ARB_LOCK: begin
          if (can_send) begin
            state_q <= ARB_IDLE;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      out_op    <= req_op[winner];
      out_addr  <= req_addr[winner];
      out_wdata <= req_wdata[winner];
      out_id    <= {winner, req_id[winner]};  // initiator index on top
    end
  end

  // grant only to a waiting head
  a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && ((grant & ~req_valid) == '0));

  a_valid_credit: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> cnt_q != '0);

endmodule

// File: xbar/soc_rsp_router.sv
/* per-initiator response router with per-target slots, id strip and credits */
`timescale 1ns/1ps
`include "soc_bus_cfg.svh"

module soc_rsp_router
  import soc_bus_req_pkg::*, soc_bus_map_pkg::*;
#(
  parameter soc_init_idx_t INIT_IDX = '0
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [`SOC_N_TGT-1:0]                  rsp_valid,
  input  logic [`SOC_N_TGT-1:0][`SOC_DW-1:0]     rsp_rdata,
  input  soc_status_e [`SOC_N_TGT-1:0]           rsp_status,
  input  logic [`SOC_N_TGT-1:0][`SOC_IW_OUP-1:0] rsp_id,
  output logic [`SOC_N_TGT-1:0]                  rsp_credit,
  output logic                                   out_valid,
  output logic [`SOC_DW-1:0]                     out_rdata,
  output soc_status_e                            out_status,
  output logic [`SOC_IW_INP-1:0]                 out_id,
  input  logic                                   out_credit
);

  localparam int unsigned N     = `SOC_N_TGT;
  localparam int unsigned DEPTH = `SOC_FIFO_DEPTH;
  localparam int unsigned PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW    = $clog2(DEPTH + 1);

  logic [`SOC_DW-1:0]     slot_rdata  [N][DEPTH];
  soc_status_e            slot_status [N][DEPTH];
  logic [`SOC_IW_INP-1:0] slot_id     [N][DEPTH];
  logic [PW-1:0]          wr_ptr [N];
  logic [PW-1:0]          rd_ptr [N];
  logic [CW-1:0]          fill   [N];
  logic [CW-1:0]          owed   [N];
  logic [N-1:0]           claim;
  logic [N-1:0]           free;
  logic [N-1:0]           full;
  logic [N-1:0]           ret;
  soc_tgt_idx_t           rr_q;
  soc_tgt_idx_t           sel;
  soc_init_idx_t          tdm_q;  // same count in every router
  logic                   found;
  logic                   can_send;
  logic                   drain;
  logic [CW-1:0]          cnt_q;

  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // credit returns are time sliced so the ORed pulses never collide
  always_comb begin
    for (int t = 0; t < N; t++) begin
      claim[t] = rsp_valid[t] && (rsp_id[t][`SOC_IW_OUP-1 -: 2] == INIT_IDX);
      free[t]  = drain && (sel == soc_tgt_idx_t'(t));
      full[t]  = fill[t] == CW'(DEPTH);
      ret[t]   = (tdm_q == INIT_IDX) && (owed[t] != '0);
    end
  end

  always_comb begin
    int unsigned idx;
    sel   = rr_q;
    found = 1'b0;
    for (int k = 0; k < N; k++) begin
      idx = (int'(rr_q) + k) % N;
      if (!found && fill[idx] != '0) begin
        found = 1'b1;
        sel   = soc_tgt_idx_t'(idx);
      end
    end
  end

  assign can_send = cnt_q > CW'(out_valid);
  assign drain    = found && can_send;

  always_ff @(posedge clk) begin
    for (int t = 0; t < N; t++) begin
      if (claim[t]) begin
        slot_rdata[t][wr_ptr[t]]  <= rsp_rdata[t];
        slot_status[t][wr_ptr[t]] <= rsp_status[t];
        slot_id[t][wr_ptr[t]]     <= rsp_id[t][`SOC_IW_INP-1:0];  // prefix dropped
      end
    end
    if (drain) begin
      out_rdata  <= slot_rdata[sel][rd_ptr[sel]];
      out_status <= slot_status[sel][rd_ptr[sel]];
      out_id     <= slot_id[sel][rd_ptr[sel]];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < N; t++) begin
        wr_ptr[t] <= '0;
        rd_ptr[t] <= '0;
        fill[t]   <= '0;
        owed[t]   <= (INIT_IDX == '0) ? CW'(DEPTH) : '0;  // router 0 gives the reset burst
      end
      rsp_credit <= '0;
      rr_q       <= '0;
      tdm_q      <= '0;
      cnt_q      <= '0;
      out_valid  <= 1'b0;
    end else begin
      tdm_q     <= (tdm_q == soc_init_idx_t'(`SOC_N_INIT - 1)) ? '0 : tdm_q + 1'b1;
      cnt_q     <= cnt_q + CW'(out_credit) - CW'(out_valid);
      out_valid <= drain;
      if (drain) begin
        rr_q <= (sel == soc_tgt_idx_t'(N - 1)) ? '0 : sel + 1'b1;
      end
      for (int t = 0; t < N; t++) begin
        rsp_credit[t] <= ret[t];
        owed[t]       <= owed[t] + CW'(free[t]) - CW'(ret[t]);
        fill[t]       <= fill[t] + CW'(claim[t]) - CW'(free[t]);
        if (claim[t]) begin
          wr_ptr[t] <= ptr_inc(wr_ptr[t]);
        end
        if (free[t]) begin
          rd_ptr[t] <= ptr_inc(rd_ptr[t]);
        end
      end
    end
  end

  // targets only send against returned credit
  a_slot_free: assert property (@(posedge clk) disable iff (rst)
    (claim & full) == '0);

endmodule
